//--- build.f
+incdir+tests
hw/bomber_pkg.sv
hw/invincibility_timer.sv
hw/position_counter.sv
hw/tile_decoder.sv
hw/player_stats.sv
hw/player_motion.sv
hw/bomber_player_core.sv
tests/bomber_tb.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing -Wno-fatal
TOP      = bomber_tb
FILELIST = build.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJDIR)

//--- tests/bomber_tb_table.svh
// table of tile checks, movement steps and waits with expected values, and its entry count.
`ifndef BOMBER_TB_TABLE_SVH
`define BOMBER_TB_TABLE_SVH

localparam int TABLE_LEN = 39;

task automatic load_table;
	// check: name, player, corner, tile, hit, lives, speed, bomb, radius, potency, pass, clear, inv.
	// step: name, x_dir, x_move, y_dir, y_move, p1 x, p2 x, p1 y, p2 y.
	add_step("blocked at reset", 2'b11, 2'b11, 2'b11, 2'b11, 88, 216, 112, 112);
	add_check("p1 c0 empty", 0, 0, bomber_pkg::TILE_EMPTY, 0, 3, 4, 0, 0, 0, 4'b0001, 0, 0);
	add_check("p1 c1 empty", 0, 1, bomber_pkg::TILE_EMPTY, 0, 3, 4, 0, 0, 0, 4'b0011, 0, 0);
	add_check("p1 c2 empty", 0, 2, bomber_pkg::TILE_EMPTY, 0, 3, 4, 0, 0, 0, 4'b0111, 0, 0);
	add_check("p1 c3 empty", 0, 3, bomber_pkg::TILE_EMPTY, 0, 3, 4, 0, 0, 0, 4'b1111, 0, 0);
	add_step("p1 x+ open", 2'b01, 2'b01, 2'b00, 2'b00, 92, 216, 112, 112);
	add_check("p1 c1 wall", 0, 1, bomber_pkg::TILE_WALL, 0, 3, 4, 0, 0, 0, 4'b1101, 0, 0);
	add_step("p1 x+ blocked", 2'b01, 2'b01, 2'b00, 2'b00, 92, 216, 112, 112);
	add_step("p1 x- open", 2'b00, 2'b01, 2'b00, 2'b00, 88, 216, 112, 112);
	add_check("p1 speed 5", 0, 1, bomber_pkg::TILE_PU_SPEED, 0, 3, 5, 0, 0, 0, 4'b1111, 1, 0);
	add_check("p1 speed 6", 0, 1, bomber_pkg::TILE_PU_SPEED, 0, 3, 6, 0, 0, 0, 4'b1111, 1, 0);
	add_check("p1 speed 7", 0, 1, bomber_pkg::TILE_PU_SPEED, 0, 3, 7, 0, 0, 0, 4'b1111, 1, 0);
	add_check("p1 speed 8", 0, 1, bomber_pkg::TILE_PU_SPEED, 0, 3, 8, 0, 0, 0, 4'b1111, 1, 0);
	add_check("p1 speed cap", 0, 1, bomber_pkg::TILE_PU_SPEED, 0, 3, 8, 0, 0, 0, 4'b1111, 1, 0);
	add_check("p1 bomb 1", 0, 0, bomber_pkg::TILE_PU_BOMB, 0, 3, 8, 1, 0, 0, 4'b1111, 1, 0);
	add_check("p1 bomb 2", 0, 0, bomber_pkg::TILE_PU_BOMB, 0, 3, 8, 2, 0, 0, 4'b1111, 1, 0);
	add_check("p1 bomb cap", 0, 0, bomber_pkg::TILE_PU_BOMB, 0, 3, 8, 2, 0, 0, 4'b1111, 1, 0);
	add_check("p1 radius 1", 0, 0, bomber_pkg::TILE_PU_RADIUS, 0, 3, 8, 2, 1, 0, 4'b1111, 1, 0);
	add_check("p1 radius 2", 0, 0, bomber_pkg::TILE_PU_RADIUS, 0, 3, 8, 2, 2, 0, 4'b1111, 1, 0);
	add_check("p1 radius cap", 0, 0, bomber_pkg::TILE_PU_RADIUS, 0, 3, 8, 2, 2, 0, 4'b1111, 1, 0);
	add_check("p1 potency 1", 0, 0, bomber_pkg::TILE_PU_POTENCY, 0, 3, 8, 2, 2, 1, 4'b1111, 1, 0);
	add_check("p1 potency 2", 0, 0, bomber_pkg::TILE_PU_POTENCY, 0, 3, 8, 2, 2, 2, 4'b1111, 1, 0);
	add_check("p1 potency cap", 0, 0, bomber_pkg::TILE_PU_POTENCY, 0, 3, 8, 2, 2, 2, 4'b1111, 1, 0);
	add_check("p1 throw", 0, 0, bomber_pkg::TILE_PU_THROW, 0, 3, 8, 2, 2, 2, 4'b1111, 1, 0);
	add_check("p1 first hit", 0, 0, bomber_pkg::TILE_EXPLOSION, 1, 2, 8, 2, 2, 2, 4'b1110, 0, 1);
	add_check("p1 hit while inv", 0, 0, bomber_pkg::TILE_EXPLOSION, 1, 2, 8, 2, 2, 2, 4'b1110, 0, 1);
	add_wait("p1 inv window");
	add_check("p1 hit after inv", 0, 0, bomber_pkg::TILE_EXPLOSION, 1, 1, 8, 2, 2, 2, 4'b1110, 0, 1);
	add_check("p1 life at 1", 0, 0, bomber_pkg::TILE_PU_LIFE, 0, 2, 8, 2, 2, 2, 4'b1111, 1, 1);
	add_check("p1 life at 2", 0, 0, bomber_pkg::TILE_PU_LIFE, 0, 2, 8, 2, 2, 2, 4'b1111, 1, 1);
	add_check("p2 c0 sprite", 1, 0, bomber_pkg::TILE_P1, 0, 3, 4, 0, 0, 0, 4'b0001, 0, 0);
	add_check("p2 c1 sprite", 1, 1, bomber_pkg::TILE_P2_INV, 0, 3, 4, 0, 0, 0, 4'b0011, 0, 0);
	add_check("p2 c3 empty", 1, 3, bomber_pkg::TILE_EMPTY, 0, 3, 4, 0, 0, 0, 4'b1011, 0, 0);
	add_step("p2 x+ 220", 2'b10, 2'b10, 2'b00, 2'b00, 88, 220, 112, 112);
	add_step("p2 x+ 224", 2'b10, 2'b10, 2'b00, 2'b00, 88, 224, 112, 112);
	add_step("p2 x+ 228", 2'b10, 2'b10, 2'b00, 2'b00, 88, 228, 112, 112);
	add_step("p2 x+ 232", 2'b10, 2'b10, 2'b00, 2'b00, 88, 232, 112, 112);
	add_step("p2 x+ at bound", 2'b10, 2'b10, 2'b00, 2'b00, 88, 232, 112, 112);
	add_step("p2 y- open", 2'b00, 2'b00, 2'b00, 2'b10, 88, 232, 112, 108);
endtask

`endif

//--- tests/bomber_tb.sv
// testbench for the player core with clock, reset, table-driven checks, timeout and summary.
`timescale 1ns/1ps

module bomber_tb;

	localparam int KIND_CHECK = 0;
	localparam int KIND_STEP = 1;
	localparam int KIND_WAIT = 2;

	logic                     clock;
	logic                     reset;
	logic                     check_valid;
	logic                     check_ready;
	logic                     check_player;
	bomber_pkg::corner_t      check_corner;
	bomber_pkg::tile_id_t     check_tile;
	logic                     check_explosion;
	logic                     step;
	logic [1:0]               x_dir;
	logic [1:0]               x_move;
	logic [1:0]               y_dir;
	logic [1:0]               y_move;
	logic [1:0][3:0]          passable;
	bomber_pkg::lives_t [1:0] lives;
	bomber_pkg::speed_t [1:0] speed;
	bomber_pkg::stat_t [1:0]  bomb_level;
	bomber_pkg::stat_t [1:0]  radius_level;
	bomber_pkg::stat_t [1:0]  potency_level;
	logic [1:0]               invincible;
	logic                     clear_tile;
	bomber_pkg::coord_t [1:0] pos_x;
	bomber_pkg::coord_t [1:0] pos_y;

	string       names [$];
	int          kinds [$];
	logic [7:0]  stims [$];		// packed check fields or step dirs and moves.
	logic [35:0] expects [$];
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;

	`include "bomber_tb_table.svh"

	localparam int CYCLE_LIMIT = 4 * TABLE_LEN + 200;

	bomber_player_core bomber_player_core_i (.*);

	always #10 clock = ~clock;

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: table not finished after %0d cycles", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic add_check(input string name, input bit player, input bomber_pkg::corner_t corner,
		input bomber_pkg::tile_id_t tile, input bit hit, input bomber_pkg::lives_t exp_lives,
		input bomber_pkg::speed_t exp_speed, input bomber_pkg::stat_t exp_bomb,
		input bomber_pkg::stat_t exp_radius, input bomber_pkg::stat_t exp_potency,
		input logic [3:0] exp_pass, input bit exp_clear, input bit exp_inv);
		names.push_back(name);
		kinds.push_back(KIND_CHECK);
		stims.push_back({player, corner, tile, hit});
		expects.push_back({18'd0, exp_lives, exp_speed, exp_bomb, exp_radius, exp_potency,
			exp_pass, exp_clear, exp_inv});
	endtask

	task automatic add_step(input string name, input logic [1:0] xd, input logic [1:0] xm,
		input logic [1:0] yd, input logic [1:0] ym, input bomber_pkg::coord_t p1_x,
		input bomber_pkg::coord_t p2_x, input bomber_pkg::coord_t p1_y,
		input bomber_pkg::coord_t p2_y);
		names.push_back(name);
		kinds.push_back(KIND_STEP);
		stims.push_back({xd, xm, yd, ym});
		expects.push_back({p1_x, p2_x, p1_y, p2_y});
	endtask

	task automatic add_wait(input string name);
		names.push_back(name);
		kinds.push_back(KIND_WAIT);
		stims.push_back(8'd0);
		expects.push_back(36'd0);
	endtask

	task automatic compare_field(input string test, input string field,
		input logic [8:0] expected, input logic [8:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %s %s: expected %0d, actual %0d", test, field, expected, actual);
		end
	endtask

	// each entry starts and ends on a falling edge.
	task automatic apply_entry(input int i);
		logic [7:0]  stim;
		logic [35:0] exp;
		int          p;
		stim = stims[i];
		exp = expects[i];
		p = int'(stim[7]);
		if (kinds[i] == KIND_CHECK)
		begin
			check_player = stim[7];
			check_corner = stim[6:5];
			check_tile = bomber_pkg::tile_id_t'(stim[4:1]);
			check_explosion = stim[0];
			check_valid = 1'b1;
			while (!check_ready)
				@(negedge clock);
			@(posedge clock);		// transfer edge.
			@(negedge clock);
			check_valid = 1'b0;
			repeat (2) @(posedge clock);		// decode, then execute.
			@(negedge clock);
			compare_field(names[i], "lives", 9'(exp[17:16]), 9'(lives[p]));
			compare_field(names[i], "speed", 9'(exp[15:12]), 9'(speed[p]));
			compare_field(names[i], "bomb", 9'(exp[11:10]), 9'(bomb_level[p]));
			compare_field(names[i], "radius", 9'(exp[9:8]), 9'(radius_level[p]));
			compare_field(names[i], "potency", 9'(exp[7:6]), 9'(potency_level[p]));
			compare_field(names[i], "passable", 9'(exp[5:2]), 9'(passable[p]));
			compare_field(names[i], "clear_tile", 9'(exp[1]), 9'(clear_tile));
			compare_field(names[i], "invincible", 9'(exp[0]), 9'(invincible[p]));
			compare_field(names[i], "check_ready", 9'd1, 9'(check_ready));
		end
		else if (kinds[i] == KIND_STEP)
		begin
			{x_dir, x_move, y_dir, y_move} = stim;
			step = 1'b1;
			@(negedge clock);
			step = 1'b0;
			x_move = 2'b00;
			y_move = 2'b00;
			compare_field(names[i], "p1 x", exp[35:27], pos_x[0]);
			compare_field(names[i], "p2 x", exp[26:18], pos_x[1]);
			compare_field(names[i], "p1 y", exp[17:9], pos_y[0]);
			compare_field(names[i], "p2 y", exp[8:0], pos_y[1]);
		end
		else
			repeat (bomber_pkg::INV_CYCLES) @(negedge clock);
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		check_valid = 1'b0;
		check_player = 1'b0;
		check_corner = '0;
		check_tile = bomber_pkg::TILE_EMPTY;
		check_explosion = 1'b0;
		step = 1'b0;
		x_dir = '0;
		x_move = '0;
		y_dir = '0;
		y_move = '0;
		load_table();
		if (names.size() != TABLE_LEN)
		begin
			errors++;
			$display("table holds %0d entries instead of %0d", names.size(), TABLE_LEN);
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < names.size(); i++)
			apply_entry(i);
		$display("entries: %0d, checks: %0d, errors: %0d", names.size(), checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- hw/bomber_player_core.sv
// bomber_player_core: top level joining tile decode, player stats and player motion.
`timescale 1ns/1ps

module bomber_player_core (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     check_valid,
	output logic                     check_ready,
	input  logic                     check_player,
	input  bomber_pkg::corner_t      check_corner,
	input  bomber_pkg::tile_id_t     check_tile,
	input  logic                     check_explosion,
	input  logic                     step,
	input  logic [1:0]               x_dir,
	input  logic [1:0]               x_move,
	input  logic [1:0]               y_dir,
	input  logic [1:0]               y_move,
	output logic [1:0][3:0]          passable,
	output bomber_pkg::lives_t [1:0] lives,
	output bomber_pkg::speed_t [1:0] speed,
	output bomber_pkg::stat_t [1:0]  bomb_level,
	output bomber_pkg::stat_t [1:0]  radius_level,
	output bomber_pkg::stat_t [1:0]  potency_level,
	output logic [1:0]               invincible,
	output logic                     clear_tile,
	output bomber_pkg::coord_t [1:0] pos_x,
	output bomber_pkg::coord_t [1:0] pos_y
);

	logic                dec_valid;
	logic                dec_player;
	bomber_pkg::corner_t dec_corner;
	logic                dec_passable;
	bomber_pkg::pickup_t dec_pickup;
	logic                dec_hit;

	tile_decoder tile_decoder_i (
		.clock           (clock),
		.reset           (reset),
		.check_valid     (check_valid),
		.check_ready     (check_ready),
		.check_player    (check_player),
		.check_corner    (check_corner),
		.check_tile      (check_tile),
		.check_explosion (check_explosion),
		.dec_valid       (dec_valid),
		.dec_player      (dec_player),
		.dec_corner      (dec_corner),
		.dec_passable    (dec_passable),
		.dec_pickup      (dec_pickup),
		.dec_hit         (dec_hit)
	);

	player_stats player_stats_i (
		.clock         (clock),
		.reset         (reset),
		.dec_valid     (dec_valid),
		.dec_player    (dec_player),
		.dec_corner    (dec_corner),
		.dec_passable  (dec_passable),
		.dec_pickup    (dec_pickup),
		.dec_hit       (dec_hit),
		.passable      (passable),
		.lives         (lives),
		.speed         (speed),
		.bomb_level    (bomb_level),
		.radius_level  (radius_level),
		.potency_level (potency_level),
		.invincible    (invincible),
		.clear_tile    (clear_tile)
	);

	// movement reads the passability bits held by the stats stage.
	player_motion player_motion_i (
		.clock    (clock),
		.reset    (reset),
		.step     (step),
		.x_dir    (x_dir),
		.x_move   (x_move),
		.y_dir    (y_dir),
		.y_move   (y_move),
		.passable (passable),
		.speed    (speed),
		.pos_x    (pos_x),
		.pos_y    (pos_y)
	);

endmodule

//--- hw/player_motion.sv
// player_motion: gates each axis of both players by corner passability.
`timescale 1ns/1ps

module player_motion (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     step,
	input  logic [1:0]               x_dir,
	input  logic [1:0]               x_move,
	input  logic [1:0]               y_dir,
	input  logic [1:0]               y_move,
	input  logic [1:0][3:0]          passable,
	input  bomber_pkg::speed_t [1:0] speed,
	output bomber_pkg::coord_t [1:0] pos_x,
	output bomber_pkg::coord_t [1:0] pos_y
);

	logic [1:0] x_open;
	logic [1:0] y_open;
	logic [1:0] x_enable;
	logic [1:0] y_enable;

	genvar p;
	generate
		for (p = 0; p < 2; p++)
		begin : g_player
			// corners ahead: 1,3 for +x, 0,2 for -x, 2,3 for +y, 0,1 for -y.
			assign x_open[p] = x_dir[p] ? (passable[p][1] && passable[p][3])
				: (passable[p][0] && passable[p][2]);
			assign y_open[p] = y_dir[p] ? (passable[p][2] && passable[p][3])
				: (passable[p][0] && passable[p][1]);
			assign x_enable[p] = step && x_move[p] && x_open[p];
			assign y_enable[p] = step && y_move[p] && y_open[p];

			position_counter position_x_i (
				.clock       (clock),
				.reset       (reset),
				.start_coord ((p == 0) ? bomber_pkg::P1_START_X : bomber_pkg::P2_START_X),
				.min_coord   (bomber_pkg::ARENA_X_MIN),
				.max_coord   (bomber_pkg::ARENA_X_MAX),
				.step        (speed[p]),
				.enable      (x_enable[p]),
				.direction   (x_dir[p]),
				.coord       (pos_x[p])
			);

			position_counter position_y_i (
				.clock       (clock),
				.reset       (reset),
				.start_coord (bomber_pkg::START_Y),
				.min_coord   (bomber_pkg::ARENA_Y_MIN),
				.max_coord   (bomber_pkg::ARENA_Y_MAX),
				.step        (speed[p]),
				.enable      (y_enable[p]),
				.direction   (y_dir[p]),
				.coord       (pos_y[p])
			);
		end
	endgenerate

endmodule

//--- hw/player_stats.sv
// player_stats: applies decoded checks to passability, lives, speed and power-up levels.
`timescale 1ns/1ps

module player_stats (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          dec_valid,
	input  logic                          dec_player,
	input  bomber_pkg::corner_t           dec_corner,
	input  logic                          dec_passable,
	input  bomber_pkg::pickup_t           dec_pickup,
	input  logic                          dec_hit,
	output logic [1:0][3:0]               passable,
	output bomber_pkg::lives_t [1:0]      lives,
	output bomber_pkg::speed_t [1:0]      speed,
	output bomber_pkg::stat_t [1:0]       bomb_level,
	output bomber_pkg::stat_t [1:0]       radius_level,
	output bomber_pkg::stat_t [1:0]       potency_level,
	output logic [1:0]                    invincible,
	output logic                          clear_tile
);

	logic       hit_take;
	logic [1:0] timer_start;

	// a hit only counts outside the invincibility window.
	assign hit_take = dec_valid && dec_hit && !invincible[dec_player];

	genvar p;
	generate
		for (p = 0; p < 2; p++)
		begin : g_inv
			assign timer_start[p] = hit_take && (dec_player == 1'(p));

			invincibility_timer invincibility_timer_i (
				.clock      (clock),
				.reset      (reset),
				.start      (timer_start[p]),
				.invincible (invincible[p])
			);
		end
	endgenerate

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			passable <= '0;
			lives <= {bomber_pkg::LIVES_START, bomber_pkg::LIVES_START};
			speed <= {bomber_pkg::SPEED_START, bomber_pkg::SPEED_START};
			bomb_level <= '0;
			radius_level <= '0;
			potency_level <= '0;
			clear_tile <= 1'b0;
		end
		else
		begin
			clear_tile <= dec_valid && (dec_pickup != bomber_pkg::PU_NONE);
			if (dec_valid)
			begin
				passable[dec_player][dec_corner] <= dec_passable;

				if (hit_take && lives[dec_player] != '0)
					lives[dec_player] <= lives[dec_player] - 1'b1;

				case (dec_pickup)
					bomber_pkg::PU_BOMB:
					begin
						if (bomb_level[dec_player] < bomber_pkg::STAT_LIMIT)
							bomb_level[dec_player] <= bomb_level[dec_player] + 1'b1;
					end
					bomber_pkg::PU_RADIUS:
					begin
						if (radius_level[dec_player] < bomber_pkg::STAT_LIMIT)
							radius_level[dec_player] <= radius_level[dec_player] + 1'b1;
					end
					bomber_pkg::PU_POTENCY:
					begin
						if (potency_level[dec_player] < bomber_pkg::STAT_LIMIT)
							potency_level[dec_player] <= potency_level[dec_player] + 1'b1;
					end
					bomber_pkg::PU_LIFE:
					begin
						// the hit wins when both land in one check.
						if (!hit_take && lives[dec_player] < bomber_pkg::LIFE_PICKUP_CAP)
							lives[dec_player] <= lives[dec_player] + 1'b1;
					end
					bomber_pkg::PU_SPEED:
					begin
						if (speed[dec_player] < bomber_pkg::SPEED_LIMIT)
							speed[dec_player] <= speed[dec_player] + 1'b1;
					end
					default:
					begin
						// throw pickup is only cleared from the map.
					end
				endcase
			end
		end
	end

endmodule

//--- hw/tile_decoder.sv
// tile_decoder: registered decode of one tile check into passability, pickup kind and hit.
`timescale 1ns/1ps

module tile_decoder (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 check_valid,
	output logic                 check_ready,
	input  logic                 check_player,
	input  bomber_pkg::corner_t  check_corner,
	input  bomber_pkg::tile_id_t check_tile,
	input  logic                 check_explosion,
	output logic                 dec_valid,
	output logic                 dec_player,
	output bomber_pkg::corner_t  dec_corner,
	output logic                 dec_passable,
	output bomber_pkg::pickup_t  dec_pickup,
	output logic                 dec_hit
);

	logic                 cap_valid;
	logic                 cap_player;
	bomber_pkg::corner_t  cap_corner;
	bomber_pkg::tile_id_t cap_tile;
	logic                 cap_explosion;
	logic                 transfer;
	logic                 tile_passable;
	bomber_pkg::pickup_t  tile_pickup;

	assign check_ready = 1'b1;		// stats stage never stalls.
	assign transfer = check_valid && check_ready;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			cap_valid <= 1'b0;
			dec_valid <= 1'b0;
		end
		else
		begin
			cap_valid <= transfer;
			dec_valid <= cap_valid;
		end
	end

	// capture the check on the handshake.
	always_ff @(posedge clock)
	begin
		if (transfer)
		begin
			cap_player <= check_player;
			cap_corner <= check_corner;
			cap_tile <= check_tile;
			cap_explosion <= check_explosion;
		end
	end

	always_comb
	begin
		tile_passable = 1'b0;		// walls, bricks, bombs and the rest block.
		tile_pickup = bomber_pkg::PU_NONE;
		case (cap_tile)
			bomber_pkg::TILE_EMPTY:      tile_passable = 1'b1;
			bomber_pkg::TILE_PU_BOMB:
			begin
				tile_passable = 1'b1;
				tile_pickup = bomber_pkg::PU_BOMB;
			end
			bomber_pkg::TILE_PU_RADIUS:
			begin
				tile_passable = 1'b1;
				tile_pickup = bomber_pkg::PU_RADIUS;
			end
			bomber_pkg::TILE_PU_POTENCY:
			begin
				tile_passable = 1'b1;
				tile_pickup = bomber_pkg::PU_POTENCY;
			end
			bomber_pkg::TILE_PU_THROW:
			begin
				tile_passable = 1'b1;
				tile_pickup = bomber_pkg::PU_THROW;
			end
			bomber_pkg::TILE_PU_LIFE:
			begin
				tile_passable = 1'b1;
				tile_pickup = bomber_pkg::PU_LIFE;
			end
			bomber_pkg::TILE_PU_SPEED:
			begin
				tile_passable = 1'b1;
				tile_pickup = bomber_pkg::PU_SPEED;
			end
			bomber_pkg::TILE_P1, bomber_pkg::TILE_P2,
			bomber_pkg::TILE_P1_INV, bomber_pkg::TILE_P2_INV:
				tile_passable = 1'b1;	// player sprites can be walked over.
			default:
				tile_passable = 1'b0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (cap_valid)
		begin
			dec_player <= cap_player;
			dec_corner <= cap_corner;
			dec_passable <= tile_passable;
			dec_pickup <= tile_pickup;
			dec_hit <= cap_explosion;
		end
	end

endmodule

//--- hw/position_counter.sv
// position_counter: one bounded coordinate axis stepped up or down by the speed.
`timescale 1ns/1ps

module position_counter (
	input  logic                clock,
	input  logic                reset,
	input  bomber_pkg::coord_t  start_coord,
	input  bomber_pkg::coord_t  min_coord,
	input  bomber_pkg::coord_t  max_coord,
	input  bomber_pkg::speed_t  step,
	input  logic                enable,
	input  logic                direction,
	output bomber_pkg::coord_t  coord
);

	bomber_pkg::coord_t         step_wide;
	logic [bomber_pkg::COORD_W:0] up_sum;
	logic [bomber_pkg::COORD_W:0] low_sum;

	assign step_wide = bomber_pkg::coord_t'(step);
	assign up_sum = {1'b0, coord} + {1'b0, step_wide};		// one extra bit so no wrap.
	assign low_sum = {1'b0, min_coord} + {1'b0, step_wide};

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			coord <= start_coord;
		else if (enable)
		begin
			if (direction)
			begin
				if (up_sum <= {1'b0, max_coord})
					coord <= up_sum[bomber_pkg::COORD_W-1:0];
			end
			else if ({1'b0, coord} >= low_sum)
				coord <= coord - step_wide;		// 1 is up, 0 is down.
		end
	end

endmodule

//--- hw/invincibility_timer.sv
// invincibility_timer: counts the invincibility window after a hit.
`timescale 1ns/1ps

module invincibility_timer (
	input  logic clock,
	input  logic reset,
	input  logic start,
	output logic invincible
);

	bomber_pkg::inv_count_t count;		// cycles left in the window.

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			count <= '0;
		else if (start && count == '0)
			count <= bomber_pkg::INV_LOAD;	// restarts are ignored while running.
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign invincible = (count != '0);

endmodule

//--- hw/bomber_pkg.sv
// bomber player datapath package: arena constants, limits, widths, tile and pickup enums.
package bomber_pkg;

	// field widths.
	localparam int COORD_W = 9;
	localparam int SPEED_W = 4;
	localparam int LIVES_W = 2;
	localparam int STAT_W = 2;

	typedef logic [COORD_W-1:0] coord_t;		// screen coordinate.
	typedef logic [SPEED_W-1:0] speed_t;		// pixels per step.
	typedef logic [LIVES_W-1:0] lives_t;
	typedef logic [STAT_W-1:0] stat_t;			// one power-up level.
	typedef logic [1:0] corner_t;				// 0 tl, 1 tr, 2 bl, 3 br.

	// map tile ids, as stored in the stage memory.
	typedef enum logic [3:0] {
		TILE_EMPTY      = 4'd0,
		TILE_WALL       = 4'd1,
		TILE_BRICK      = 4'd2,
		TILE_PU_BOMB    = 4'd3,
		TILE_PU_RADIUS  = 4'd4,
		TILE_PU_POTENCY = 4'd5,
		TILE_PU_THROW   = 4'd6,
		TILE_PU_LIFE    = 4'd7,
		TILE_PU_SPEED   = 4'd8,
		TILE_HEART      = 4'd9,
		TILE_BOMB       = 4'd10,
		TILE_EXPLOSION  = 4'd11,
		TILE_P1         = 4'd12,
		TILE_P2         = 4'd13,
		TILE_P1_INV     = 4'd14,
		TILE_P2_INV     = 4'd15
	} tile_id_t;

	typedef enum logic [2:0] {
		PU_NONE,
		PU_BOMB,
		PU_RADIUS,
		PU_POTENCY,
		PU_THROW,
		PU_LIFE,
		PU_SPEED
	} pickup_t;

	// movement bounds.
	localparam coord_t ARENA_X_MIN = 9'd72;
	localparam coord_t ARENA_X_MAX = 9'd232;
	localparam coord_t ARENA_Y_MIN = 9'd32;
	localparam coord_t ARENA_Y_MAX = 9'd192;

	localparam coord_t P1_START_X = 9'd88;
	localparam coord_t P2_START_X = 9'd216;
	localparam coord_t START_Y = 9'd112;

	localparam lives_t LIVES_START = 2'd3;
	localparam lives_t LIFE_PICKUP_CAP = 2'd2;		// life pickup only adds below this.
	localparam speed_t SPEED_START = 4'd4;
	localparam speed_t SPEED_LIMIT = 4'd8;
	localparam stat_t STAT_LIMIT = 2'd2;			// bomb, radius and potency cap.

	// invincibility window after a hit, in clock cycles.
	localparam int INV_CYCLES = 64;
	localparam int INV_CNT_W = $clog2(INV_CYCLES + 1);
	typedef logic [INV_CNT_W-1:0] inv_count_t;
	localparam inv_count_t INV_LOAD = inv_count_t'(INV_CYCLES);

endpackage
